// File: logic/arena_pkg.sv
package arena_pkg;

    // ==============================
    // pixel bus and match state
    // ==============================

    typedef struct packed {
        logic [10:0] hcount;
        logic [10:0] vcount;
        logic        hsync;
        logic        vsync;
        logic        hblnk;
        logic        vblnk;
        logic [11:0] rgb; // 4 bits per colour, red in the top nibble.
    } vga_bus_t;

    typedef enum logic [1:0] {
        MATCH_FIGHT,
        MATCH_CAT_WON,
        MATCH_DOG_WON
    } match_state_t;

    // ==============================
    // raster timing, 1024x768 at 60 Hz
    // ==============================

    localparam logic [10:0] H_TOTAL      = 11'd1344;
    localparam logic [10:0] H_SYNC_START = 11'd1048;
    localparam logic [10:0] H_SYNC_END   = 11'd1184;
    localparam logic [10:0] H_ACTIVE     = 11'd1024;

    localparam logic [10:0] V_TOTAL      = 11'd806;
    localparam logic [10:0] V_SYNC_START = 11'd771;
    localparam logic [10:0] V_SYNC_END   = 11'd777;
    localparam logic [10:0] V_ACTIVE     = 11'd768;

    // ==============================
    // health and geometry
    // ==============================

    localparam int HEALTH_W = 10;
    localparam logic [HEALTH_W-1:0] HEALTH_MAX = 10'd500;
    localparam logic [HEALTH_W-1:0] DAMAGE     = 10'd50;

    localparam logic [10:0] BAR_Y_START   = 11'd6;
    localparam logic [10:0] BAR_Y_END     = 11'd26;
    localparam logic [10:0] CAT_X_END     = 11'd508; // cat bar shrinks towards this edge.
    localparam logic [10:0] DOG_X_START   = 11'd516;
    localparam logic [10:0] FRAME_X_START = 11'd3;
    localparam logic [10:0] FRAME_X_END   = 11'd1020;
    localparam logic [10:0] FRAME_Y_START = 11'd3;
    localparam logic [10:0] FRAME_Y_END   = 11'd29;
    localparam logic [10:0] GROUND_Y      = 11'd600;

    localparam logic [11:0] COLOUR_FRAME  = 12'hFC0;
    localparam logic [11:0] COLOUR_BAR    = 12'hF00;
    localparam logic [11:0] COLOUR_SKY    = 12'h4AF;
    localparam logic [11:0] COLOUR_GROUND = 12'h262;

endpackage

// File: logic/vga_timing.sv
`timescale 1ns/1ns

module vga_timing (
    input  logic               clk,
    input  logic               rst,
    output arena_pkg::vga_bus_t vga
);

    import arena_pkg::*;

    logic [10:0] hcount;
    logic [10:0] vcount;
    logic [10:0] hcount_nxt;
    logic [10:0] vcount_nxt;
    logic        line_end;
    logic        frame_end;

    // ==============================
    // raster counters
    // ==============================

    assign line_end  = (hcount == H_TOTAL - 11'd1);
    assign frame_end = (vcount == V_TOTAL - 11'd1);

    always_comb begin
        hcount_nxt = hcount + 11'd1;
        vcount_nxt = vcount;

        if (line_end) begin
            hcount_nxt = 11'd0;
            // the vertical counter only moves at the end of a line.
            if (frame_end) begin
                vcount_nxt = 11'd0;
            end else begin
                vcount_nxt = vcount + 11'd1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcount <= 11'd0;
            vcount <= 11'd0;
        end else begin
            hcount <= hcount_nxt;
            vcount <= vcount_nxt;
        end
    end

    // ==============================
    // sync and blanking flags
    // ==============================

    always_comb begin
        vga.hcount = hcount;
        vga.vcount = vcount;
        vga.hsync  = (hcount >= H_SYNC_START) && (hcount < H_SYNC_END); // active high.
        vga.vsync  = (vcount >= V_SYNC_START) && (vcount < V_SYNC_END);
        vga.hblnk  = (hcount >= H_ACTIVE);
        vga.vblnk  = (vcount >= V_ACTIVE);
        vga.rgb    = 12'h000; // the timing stage carries no picture.
    end

endmodule

// File: logic/draw_background.sv
`timescale 1ns/1ns

module draw_background (
    input  logic               clk,
    input  logic               rst,
    input  arena_pkg::vga_bus_t vga_in,
    output arena_pkg::vga_bus_t vga_out
);

    import arena_pkg::*;

    logic [11:0] rgb_nxt;

    always_comb begin
        if (vga_in.hblnk || vga_in.vblnk) begin
            rgb_nxt = 12'h000; // monitors expect black outside the active area.
        end else if (vga_in.vcount < GROUND_Y) begin
            rgb_nxt = COLOUR_SKY;
        end else begin
            rgb_nxt = COLOUR_GROUND;
        end
    end

    // the colour is registered together with its own coordinates.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out.hcount <= vga_in.hcount;
            vga_out.vcount <= vga_in.vcount;
            vga_out.hsync  <= vga_in.hsync;
            vga_out.vsync  <= vga_in.vsync;
            vga_out.hblnk  <= vga_in.hblnk;
            vga_out.vblnk  <= vga_in.vblnk;
            vga_out.rgb    <= rgb_nxt;
        end
    end

endmodule

// File: logic/hit_pulse.sv
`timescale 1ns/1ns

module hit_pulse (
    input  logic clk,
    input  logic rst,
    input  logic btn,
    output logic hit
);

    logic btn_meta;
    logic btn_sync;
    logic btn_prev;

    // two flops bring the raw button level into the clock domain.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
            btn_prev <= 1'b0;
        end else begin
            btn_meta <= btn;
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;
        end
    end

    // a held button gives a single strobe on its rising edge.
    assign hit = btn_sync && !btn_prev;

endmodule

// File: logic/health_bars.sv
`timescale 1ns/1ns

module health_bars (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            hit_cat,
    input  logic                            hit_dog,
    input  arena_pkg::vga_bus_t             vga_in,
    output arena_pkg::vga_bus_t             vga_out,
    output logic [arena_pkg::HEALTH_W-1:0]  hp_cat,
    output logic [arena_pkg::HEALTH_W-1:0]  hp_dog
);

    import arena_pkg::*;

    logic [10:0] cat_bar_start;
    logic [10:0] dog_bar_end;
    logic        in_frame;
    logic        in_bar_rows;
    logic        in_cat_bar;
    logic        in_dog_bar;

    // health never wraps below zero.
    function automatic logic [HEALTH_W-1:0] take_hit(input logic [HEALTH_W-1:0] hp);
        logic [HEALTH_W-1:0] result;
        if (hp > DAMAGE) begin
            result = hp - DAMAGE;
        end else begin
            result = '0;
        end
        return result;
    endfunction

    // ==============================
    // health registers
    // ==============================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hp_cat <= HEALTH_MAX;
            hp_dog <= HEALTH_MAX;
        end else begin
            if (hit_cat) begin
                hp_cat <= take_hit(hp_cat);
            end
            if (hit_dog) begin
                hp_dog <= take_hit(hp_dog);
            end
        end
    end

    // ==============================
    // bar overlay
    // ==============================

    assign cat_bar_start = CAT_X_END - {1'b0, hp_cat}; // cat bar grows to the left.
    assign dog_bar_end   = DOG_X_START + {1'b0, hp_dog};

    assign in_frame = (vga_in.hcount >= FRAME_X_START) && (vga_in.hcount < FRAME_X_END) &&
                      (vga_in.vcount >= FRAME_Y_START) && (vga_in.vcount < FRAME_Y_END);

    assign in_bar_rows = (vga_in.vcount >= BAR_Y_START) && (vga_in.vcount < BAR_Y_END);

    assign in_cat_bar = in_bar_rows &&
                        (vga_in.hcount >= cat_bar_start) && (vga_in.hcount < CAT_X_END);

    assign in_dog_bar = in_bar_rows &&
                        (vga_in.hcount >= DOG_X_START) && (vga_in.hcount < dog_bar_end);

    always_comb begin
        vga_out = vga_in;

        if (in_frame) begin
            vga_out.rgb = COLOUR_FRAME;
        end

        // the bars sit inside the frame and are painted over it.
        if (in_cat_bar || in_dog_bar) begin
            vga_out.rgb = COLOUR_BAR;
        end
    end

endmodule

// File: logic/match_ctrl.sv
`timescale 1ns/1ns

module match_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            press_cat,
    input  logic                            press_dog,
    input  logic [arena_pkg::HEALTH_W-1:0]  hp_cat,
    input  logic [arena_pkg::HEALTH_W-1:0]  hp_dog,
    output logic                            hit_cat,
    output logic                            hit_dog,
    output arena_pkg::match_state_t         winner
);

    import arena_pkg::*;

    match_state_t state;
    match_state_t state_nxt;

    always_comb begin
        state_nxt = state;

        if (state == MATCH_FIGHT) begin
            // the cat check comes first, so a double knockout goes to the dog.
            if (hp_cat == '0) begin
                state_nxt = MATCH_DOG_WON;
            end else if (hp_dog == '0) begin
                state_nxt = MATCH_CAT_WON;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= MATCH_FIGHT;
        end else begin
            state <= state_nxt;
        end
    end

    assign hit_cat = press_cat && (state == MATCH_FIGHT); // hits stop once a winner is known.
    assign hit_dog = press_dog && (state == MATCH_FIGHT);

    assign winner = state;

endmodule

// File: logic/arena_top.sv
`timescale 1ns/1ns

module arena_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            btn_cat,
    input  logic                            btn_dog,
    output arena_pkg::vga_bus_t             pix,
    output logic [arena_pkg::HEALTH_W-1:0]  hp_cat,
    output logic [arena_pkg::HEALTH_W-1:0]  hp_dog,
    output arena_pkg::match_state_t         winner
);

    import arena_pkg::*;

    vga_bus_t timing_bus;
    vga_bus_t bg_bus;
    logic     press_cat;
    logic     press_dog;
    logic     hit_cat;
    logic     hit_dog;

    // ==============================
    // picture pipeline
    // ==============================

    vga_timing timing_i (.clk, .rst, .vga(timing_bus));

    draw_background background_i (.clk, .rst, .vga_in(timing_bus), .vga_out(bg_bus));

    health_bars bars_i (
        .clk, .rst,
        .hit_cat, .hit_dog,
        .vga_in(bg_bus), .vga_out(pix),
        .hp_cat, .hp_dog
    );

    // ==============================
    // player input and match rules
    // ==============================

    hit_pulse cat_pulse_i (.clk, .rst, .btn(btn_cat), .hit(press_cat));

    hit_pulse dog_pulse_i (.clk, .rst, .btn(btn_dog), .hit(press_dog));

    match_ctrl match_i (
        .clk, .rst,
        .press_cat, .press_dog,
        .hp_cat, .hp_dog,
        .hit_cat, .hit_dog,
        .winner
    );

endmodule

// File: verification/arena_tb.sv
`timescale 1ns/1ns

module arena_tb;

    import arena_pkg::*;

    localparam longint FRAME_CYCLES = longint'(H_TOTAL) * longint'(V_TOTAL);
    localparam int     NUM_PROBES   = 13; // pixel waits, each at most one frame long.
    localparam longint WATCHDOG_NS  = NUM_PROBES * FRAME_CYCLES * 10 + 200_000;

    logic                clk;
    logic                rst;
    logic                btn_cat;
    logic                btn_dog;
    vga_bus_t            pix;
    logic [HEALTH_W-1:0] hp_cat;
    logic [HEALTH_W-1:0] hp_dog;
    match_state_t        winner;

    logic [HEALTH_W-1:0] exp_hp_cat;
    logic [HEALTH_W-1:0] exp_hp_dog;
    match_state_t        exp_winner;
    int                  check_errors;
    int                  failed_tests;
    int                  test_start_errors;

    arena_top dut_i (.clk, .rst, .btn_cat, .btn_dog, .pix, .hp_cat, .hp_dog, .winner);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

    // ==============================
    // reference model
    // ==============================

    function automatic logic [HEALTH_W-1:0] reduced_health(input logic [HEALTH_W-1:0] hp);
        int left;
        left = int'(hp) - int'(DAMAGE);
        if (left < 0) begin
            left = 0; // a hit never takes health below zero.
        end
        return left[HEALTH_W-1:0];
    endfunction

    task automatic record_press(input logic is_cat);
        if (exp_winner == MATCH_FIGHT) begin
            if (is_cat) begin
                exp_hp_cat = reduced_health(exp_hp_cat);
            end else begin
                exp_hp_dog = reduced_health(exp_hp_dog);
            end
            if (exp_hp_cat == '0) begin
                exp_winner = MATCH_DOG_WON;
            end else if (exp_hp_dog == '0) begin
                exp_winner = MATCH_CAT_WON;
            end
        end
    endtask

    // ==============================
    // drivers and probes
    // ==============================

    task automatic check_value(input string what, input int got, input int expected);
        assert (got == expected) else begin
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
            check_errors++;
        end
    endtask

    task automatic check_state();
        check_value("hp_cat", int'(hp_cat), int'(exp_hp_cat));
        check_value("hp_dog", int'(hp_dog), int'(exp_hp_dog));
        check_value("winner", int'(winner), int'(exp_winner));
    endtask

    task automatic press_button(input logic is_cat, input int hold_cycles);
        @(posedge clk);
        #1;
        if (is_cat) begin
            btn_cat = 1'b1;
        end else begin
            btn_dog = 1'b1;
        end
        repeat (hold_cycles) @(posedge clk);
        #1;
        btn_cat = 1'b0;
        btn_dog = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        record_press(is_cat);
    endtask

    // the bus changes on the rising edge, so it is read on the falling one.
    task automatic wait_for_pixel(input int h, input int v, output bit found);
        longint waited;
        waited = 0;
        @(negedge clk);
        while ((pix.hcount != h || pix.vcount != v) && waited < FRAME_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        found = (waited < FRAME_CYCLES);
        if (!found) begin
            $display("pixel (%0d, %0d) never appeared on the bus within one frame", h, v);
            check_errors++;
        end
    endtask

    task automatic probe_pixel(input int h, input int v, input logic [11:0] exp_rgb);
        bit found;
        wait_for_pixel(h, v, found);
        if (found) begin
            assert (pix.rgb == exp_rgb) else begin
                $display("** Error at %0t ns: pixel (%0d, %0d) is %h, expected %h",
                         $time, h, v, pix.rgb, exp_rgb);
                check_errors++;
            end
        end
    endtask

    task automatic check_line(input int v);
        bit found;
        bit exp_hsync;
        bit exp_vsync;
        bit exp_hblnk;
        bit exp_vblnk;
        int h;
        wait_for_pixel(0, v, found);
        if (found) begin
            exp_vsync = (v >= int'(V_SYNC_START)) && (v < int'(V_SYNC_END));
            exp_vblnk = (v >= int'(V_ACTIVE));
            for (h = 0; h < int'(H_TOTAL); h++) begin
                exp_hsync = (h >= int'(H_SYNC_START)) && (h < int'(H_SYNC_END));
                exp_hblnk = (h >= int'(H_ACTIVE));
                check_value("hcount", int'(pix.hcount), h);
                check_value("vcount", int'(pix.vcount), v);
                check_value("hsync", int'(pix.hsync), int'(exp_hsync));
                check_value("vsync", int'(pix.vsync), int'(exp_vsync));
                check_value("hblnk", int'(pix.hblnk), int'(exp_hblnk));
                check_value("vblnk", int'(pix.vblnk), int'(exp_vblnk));
                if (exp_hblnk || exp_vblnk) begin
                    check_value("blanked rgb", int'(pix.rgb), 0);
                end
                @(negedge clk);
            end
        end
    endtask

    task automatic scan_dog_row(input int v);
        bit found;
        int h;
        wait_for_pixel(int'(DOG_X_START), v, found);
        if (found) begin
            for (h = int'(DOG_X_START); h < int'(H_ACTIVE); h++) begin
                assert (pix.rgb != COLOUR_BAR) else begin
                    $display("** Error at %0t ns: dog bar pixel (%0d, %0d) is still red",
                             $time, h, v);
                    check_errors++;
                end
                @(negedge clk);
            end
        end
    endtask

    task automatic end_test(input int number, input string name);
        if (check_errors == test_start_errors) begin
            $display("test %0d %s: passed", number, name);
        end else begin
            $display("test %0d %s: failed", number, name);
            failed_tests++;
        end
        test_start_errors = check_errors;
    endtask

    // ==============================
    // tests
    // ==============================

    task automatic test_reset_state();
        check_state();
        check_line(1);
        check_line(int'(V_SYNC_START)); // a line inside the vertical sync pulse.
        end_test(1, "reset state and raster");
    endtask

    task automatic test_full_health_picture();
        int cat_col;
        int dog_col;
        cat_col = int'(CAT_X_END) - 1 - int'($urandom % HEALTH_MAX);
        dog_col = int'(DOG_X_START) + int'($urandom % HEALTH_MAX);
        probe_pixel(int'(FRAME_X_START), int'(FRAME_Y_START), COLOUR_FRAME);
        probe_pixel(512, 10, COLOUR_FRAME); // gap between the two bars.
        probe_pixel(cat_col, 15, COLOUR_BAR);
        probe_pixel(dog_col, 15, COLOUR_BAR);
        probe_pixel(100, 300, COLOUR_SKY);
        probe_pixel(100, 700, COLOUR_GROUND);
        end_test(2, "picture at full health");
    endtask

    task automatic test_cat_press();
        press_button(1'b1, 8);
        check_state();
        probe_pixel(int'(CAT_X_END) - int'(exp_hp_cat) - 1, 10, COLOUR_FRAME);
        probe_pixel(int'(CAT_X_END) - int'(exp_hp_cat), 10, COLOUR_BAR);
        probe_pixel(int'(DOG_X_START) + int'(exp_hp_dog) - 1, 10, COLOUR_BAR);
        probe_pixel(int'(DOG_X_START) + int'(exp_hp_dog), 10, COLOUR_FRAME);
        end_test(3, "single cat press");
    endtask

    task automatic test_held_dog();
        press_button(1'b0, 200);
        check_state();
        end_test(4, "held dog button");
    endtask

    task automatic test_dog_knockout();
        repeat (9) begin
            press_button(1'b0, 8);
        end
        check_state();
        check_value("hp_dog after knockout", int'(hp_dog), 0);
        scan_dog_row(15);
        end_test(5, "dog knockout");
    endtask

    task automatic test_after_knockout();
        press_button(1'b1, 8);
        press_button(1'b0, 8);
        check_state();
        end_test(6, "presses after knockout");
    endtask

    initial begin
        rst          = 1'b1;
        btn_cat      = 1'b0;
        btn_dog      = 1'b0;
        exp_hp_cat   = HEALTH_MAX;
        exp_hp_dog   = HEALTH_MAX;
        exp_winner   = MATCH_FIGHT;
        check_errors = 0;
        failed_tests = 0;
        test_start_errors = 0;
        void'($urandom(11));
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset_state();
        test_full_health_picture();
        test_cat_press();
        test_held_dog();
        test_dog_knockout();
        test_after_knockout();

        $display("tests run: 6, tests failed: %0d, failed checks: %0d",
                 failed_tests, check_errors);
        if (check_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
logic/arena_pkg.sv
logic/vga_timing.sv
logic/draw_background.sv
logic/hit_pulse.sv
logic/health_bars.sv
logic/match_ctrl.sv
logic/arena_top.sv
verification/arena_tb.sv
